// File: rtl/mipsPkg.sv
package mipsPkg;

  // ------------------------------------------------------------
  // widths and depths
  // ------------------------------------------------------------
  localparam int dataW     = 32;
  localparam int regAddrW  = 5;
  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;
  localparam int imemAddrW = $clog2(imemDepth); // word index, byte addr bits 7:2
  localparam int dmemAddrW = $clog2(dmemDepth);

  // ------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------
  typedef enum logic [5:0] {
    opR    = 6'h00,
    opJ    = 6'h02,
    opBeq  = 6'h04,
    opBne  = 6'h05,
    opAddi = 6'h08,
    opAndi = 6'h0c,
    opOri  = 6'h0d,
    opLw   = 6'h23,
    opSw   = 6'h2b,
    opHalt = 6'h3f  // stops fetch
  } opcodeE;

  typedef enum logic [5:0] {
    fnSll = 6'h00,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functE;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,     // signed compare
    aluSll,
    aluPassImm
  } aluOpE;

  // three views of one instruction word
  typedef struct packed {
    logic [5:0]          opcode;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;
    logic [4:0]          shamt;
    logic [5:0]          funct;
  } rFmtS;

  typedef struct packed {
    logic [5:0]          opcode;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [15:0]         imm;
  } iFmtS;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jFmtS;

  typedef union packed {
    rFmtS rFmt;
    iFmtS iFmt;
    jFmtS jFmt;
  } instrU;

  // ------------------------------------------------------------
  // stage buses
  // ------------------------------------------------------------
  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  aluSrc;    // 1: immediate as operand b
    logic  regDst;    // 1: rd, 0: rt
    aluOpE aluOp;
    logic  halt;
  } ctrlS;

  typedef struct packed {
    logic             valid;
    logic [dataW-1:0] pcPlus4;
    instrU            instr;
  } ifIdS;

  typedef struct packed {
    logic                valid;
    ctrlS                ctrl;
    logic [dataW-1:0]    pc;
    logic [dataW-1:0]    rsData;
    logic [dataW-1:0]    rtData;
    logic [dataW-1:0]    imm;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;
    logic [4:0]          shamt;
  } idExS;

  typedef struct packed {
    logic                valid;
    logic                regWrite;  // already qualified by valid
    logic                memRead;
    logic                memWrite;
    logic                halt;
    logic [dataW-1:0]    aluRes;
    logic [dataW-1:0]    storeData;
    logic [regAddrW-1:0] dest;
  } exMemS;

  typedef struct packed {
    logic                valid;
    logic                regWrite;
    logic                memToReg;
    logic                halt;
    logic [dataW-1:0]    aluRes;
    logic [dataW-1:0]    loadData;
    logic [regAddrW-1:0] dest;
  } memWbS;

  typedef struct packed {
    logic                regWrite;
    logic [regAddrW-1:0] dest;
    logic [dataW-1:0]    data;
  } fwdS;

  typedef struct packed {
    logic                 en;
    logic [imemAddrW-1:0] addr;
    logic [dataW-1:0]     data;
  } progWrS;

  typedef struct packed {
    logic                valid;
    logic [regAddrW-1:0] rd;
    logic [dataW-1:0]    data;
  } commitS;   // 38 bits

  // operand select, EX/MEM first then writeback then register value
  function automatic logic [dataW-1:0] fwdPick(
    input logic [regAddrW-1:0] idx,
    input logic [dataW-1:0]    regVal,
    input fwdS                 exF,
    input fwdS                 wbF
  );
    if (exF.regWrite && exF.dest != '0 && exF.dest == idx) begin
      return exF.data;
    end
    if (wbF.regWrite && wbF.dest != '0 && wbF.dest == idx) begin
      return wbF.data;
    end
    return regVal;
  endfunction

endpackage

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [mipsPkg::regAddrW-1:0] rs,
  input  logic [mipsPkg::regAddrW-1:0] rt,
  input  mipsPkg::fwdS                 wb,
  output logic [mipsPkg::dataW-1:0]    rsData,
  output logic [mipsPkg::dataW-1:0]    rtData
);
  import mipsPkg::*;

  logic [dataW-1:0] regs [2**regAddrW];
  logic             wrEn;

  assign wrEn = wb.regWrite && (wb.dest != '0);  // r0 never written

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 2**regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wb.dest] <= wb.data;
    end
  end

  // same-cycle write shows up on the read side
  assign rsData = (wrEn && wb.dest == rs) ? wb.data : regs[rs];
  assign rtData = (wrEn && wb.dest == rt) ? wb.data : regs[rt];

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
  input  logic                      clk,
  input  logic                      rstN,
  input  mipsPkg::progWrS           progWr,
  input  logic                      stall,
  input  logic                      redirect,
  input  logic [mipsPkg::dataW-1:0] redirectPc,
  input  logic                      halt,
  output mipsPkg::ifIdS             ifId
);
  import mipsPkg::*;

  logic [dataW-1:0] imem [imemDepth];
  logic [dataW-1:0] pc;
  logic [dataW-1:0] pcPlus4;
  logic             haltSeen;  // sticky, pc frozen for good

  assign pcPlus4 = pc + dataW'(4);

  // loader port, only honoured while reset is held
  always_ff @(posedge clk) begin
    if (!rstN && progWr.en) begin
      imem[progWr.addr] <= progWr.data;
    end
  end

  // ------------------------------------------------------------
  // program counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc       <= '0;
      haltSeen <= 1'b0;
    end else begin
      if (halt) begin
        haltSeen <= 1'b1;
      end
      if (redirect) begin
        pc <= redirectPc;                       // taken branch or j
      end else if (!stall && !halt && !haltSeen) begin
        pc <= pcPlus4;
      end
    end
  end

  // ------------------------------------------------------------
  // IF/ID register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ifId.valid <= 1'b0;
    end else if (redirect || halt || haltSeen) begin
      ifId.valid <= 1'b0;                       // squash, no delay slot
    end else if (!stall) begin
      ifId.valid   <= 1'b1;
      ifId.pcPlus4 <= pcPlus4;
      ifId.instr   <= imem[pc[imemAddrW+1:2]];
    end
    // stall: hold everything
  end

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic                      clk,
  input  logic                      rstN,
  input  mipsPkg::ifIdS             ifId,
  input  mipsPkg::exMemS            exMem,
  input  mipsPkg::fwdS              exFwd,
  input  mipsPkg::fwdS              wbFwd,
  output logic                      stall,
  output logic                      redirect,
  output logic [mipsPkg::dataW-1:0] redirectPc,
  output logic                      halt,
  output mipsPkg::idExS             idEx
);
  import mipsPkg::*;

  instrU               instr;
  opcodeE              op;
  ctrlS                ctrl;
  logic                usesRs;
  logic                usesRt;
  logic [regAddrW-1:0] rsIdx;
  logic [regAddrW-1:0] rtIdx;
  logic [dataW-1:0]    rfRs;
  logic [dataW-1:0]    rfRt;
  logic [dataW-1:0]    rsVal;
  logic [dataW-1:0]    rtVal;
  logic [dataW-1:0]    imm;
  logic [dataW-1:0]    brTarget;
  logic [dataW-1:0]    jTarget;
  logic                isBr;
  logic                takeBr;
  logic [regAddrW-1:0] exDest;
  logic                loadUse;
  logic                brDepEx;
  logic                brDepMem;

  assign instr = ifId.instr;
  assign op    = opcodeE'(instr.iFmt.opcode);
  assign rsIdx = instr.rFmt.rs;
  assign rtIdx = instr.rFmt.rt;

  regFile uRegFile (
    .clk    (clk),
    .rstN   (rstN),
    .rs     (rsIdx),
    .rt     (rtIdx),
    .wb     (wbFwd),   // write port straight from writeback
    .rsData (rfRs),
    .rtData (rfRt)
  );

  // ------------------------------------------------------------
  // control decode
  // ------------------------------------------------------------
  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = aluPassImm;
    usesRs     = 1'b0;
    usesRt     = 1'b0;
    case (op)
      opR: begin
        usesRs        = 1'b1;
        usesRt        = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (functE'(instr.rFmt.funct))
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          fnSll:   ctrl.aluOp = aluSll;
          default: ctrl.regWrite = 1'b0;  // unknown funct acts as nop
        endcase
      end
      opAddi, opAndi, opOri: begin
        usesRs        = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = (op == opAddi) ? aluAdd : (op == opAndi) ? aluAnd : aluOr;
      end
      opLw: begin
        usesRs        = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;  // base + offset
      end
      opSw: begin
        usesRs        = 1'b1;
        usesRt        = 1'b1;    // store data
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq, opBne: begin
        usesRs = 1'b1;
        usesRt = 1'b1;
      end
      opHalt:  ctrl.halt = 1'b1;
      default: ;               // j and unknown opcodes write nothing
    endcase
  end

  // andi/ori zero-extend, the rest sign-extend
  assign imm = (op == opAndi || op == opOri) ? {16'b0, instr.iFmt.imm}
                                             : {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm};

  // ------------------------------------------------------------
  // branch compare and targets
  // ------------------------------------------------------------
  assign rsVal    = fwdPick(rsIdx, rfRs, exFwd, wbFwd);
  assign rtVal    = fwdPick(rtIdx, rfRt, exFwd, wbFwd);
  assign isBr     = (op == opBeq) || (op == opBne);
  assign takeBr   = (op == opBeq && rsVal == rtVal) || (op == opBne && rsVal != rtVal);
  assign brTarget = ifId.pcPlus4 + {{14{instr.iFmt.imm[15]}}, instr.iFmt.imm, 2'b00};
  assign jTarget  = {ifId.pcPlus4[31:28], instr.jFmt.target, 2'b00};

  // hazards
  assign exDest  = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
  assign loadUse = idEx.valid && idEx.ctrl.memRead && idEx.rt != '0 &&
                   ((usesRs && idEx.rt == rsIdx) || (usesRt && idEx.rt == rtIdx));
  assign brDepEx = isBr && idEx.valid && idEx.ctrl.regWrite && exDest != '0 &&
                   (exDest == rsIdx || exDest == rtIdx);          // result not made yet
  assign brDepMem = isBr && exMem.valid && exMem.memRead && exMem.dest != '0 &&
                    (exMem.dest == rsIdx || exMem.dest == rtIdx); // load data not back yet

  assign stall      = ifId.valid && (loadUse || brDepEx || brDepMem);
  assign redirect   = ifId.valid && !stall && (takeBr || op == opJ);
  assign redirectPc = (op == opJ) ? jTarget : brTarget;
  assign halt       = ifId.valid && ctrl.halt;

  // ------------------------------------------------------------
  // ID/EX register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idEx.valid <= 1'b0;
    end else begin
      idEx.valid  <= ifId.valid && !stall;  // bubble while stalled
      idEx.ctrl   <= ctrl;
      idEx.pc     <= ifId.pcPlus4 - dataW'(4);
      idEx.rsData <= rfRs;
      idEx.rtData <= rfRt;
      idEx.imm    <= imm;
      idEx.rs     <= rsIdx;
      idEx.rt     <= rtIdx;
      idEx.rd     <= instr.rFmt.rd;
      idEx.shamt  <= instr.rFmt.shamt;
    end
  end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic           clk,
  input  logic           rstN,
  input  mipsPkg::idExS  idEx,
  input  mipsPkg::fwdS   wbFwd,
  output mipsPkg::exMemS exMem,
  output mipsPkg::fwdS   exFwd
);
  import mipsPkg::*;

  logic [dataW-1:0]    opA;
  logic [dataW-1:0]    fwdB;   // rt after forwarding, also the store data
  logic [dataW-1:0]    opB;
  logic [dataW-1:0]    aluRes;
  logic [regAddrW-1:0] dest;

  // ------------------------------------------------------------
  // operand select
  // ------------------------------------------------------------
  assign opA  = fwdPick(idEx.rs, idEx.rsData, exFwd, wbFwd);
  assign fwdB = fwdPick(idEx.rt, idEx.rtData, exFwd, wbFwd);
  assign opB  = idEx.ctrl.aluSrc ? idEx.imm : fwdB;

  // ALU
  always_comb begin
    case (idEx.ctrl.aluOp)
      aluAdd:     aluRes = opA + opB;
      aluSub:     aluRes = opA - opB;
      aluAnd:     aluRes = opA & opB;
      aluOr:      aluRes = opA | opB;
      aluSlt:     aluRes = dataW'($signed(opA) < $signed(opB));
      aluSll:     aluRes = opB << idEx.shamt;  // shifts rt
      aluPassImm: aluRes = idEx.imm;
      default:    aluRes = '0;
    endcase
  end

  assign dest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

  // ------------------------------------------------------------
  // EX/MEM register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMem.valid    <= 1'b0;
      exMem.regWrite <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.halt     <= 1'b0;
    end else begin
      exMem.valid     <= idEx.valid;
      exMem.regWrite  <= idEx.valid && idEx.ctrl.regWrite;  // bubbles write nothing
      exMem.memRead   <= idEx.valid && idEx.ctrl.memRead;
      exMem.memWrite  <= idEx.valid && idEx.ctrl.memWrite;
      exMem.halt      <= idEx.valid && idEx.ctrl.halt;
      exMem.aluRes    <= aluRes;
      exMem.storeData <= fwdB;
      exMem.dest      <= dest;
    end
  end

  // forward from own register, feeds both ALU and branch compare
  assign exFwd.regWrite = exMem.regWrite;
  assign exFwd.dest     = exMem.dest;
  assign exFwd.data     = exMem.aluRes;

endmodule

// File: rtl/memStage.sv
`timescale 1ns/1ps

module memStage (
  input  logic            clk,
  input  logic            rstN,
  input  mipsPkg::exMemS  exMem,
  output mipsPkg::fwdS    wbFwd,
  output mipsPkg::commitS commit,
  output logic            halted
);
  import mipsPkg::*;

  logic [dataW-1:0]     dmem [dmemDepth];
  logic [dmemAddrW-1:0] wordAddr;
  logic [dataW-1:0]     loadData;
  logic [dataW-1:0]     wbData;
  memWbS                memWb;

  assign wordAddr = exMem.aluRes[dmemAddrW+1:2];  // byte addr bits 7:2
  assign loadData = dmem[wordAddr];               // async read

  // ------------------------------------------------------------
  // data memory
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < dmemDepth; i++) begin
        dmem[i] <= '0;
      end
    end else if (exMem.memWrite) begin
      dmem[wordAddr] <= exMem.storeData;
    end
  end

  // MEM/WB register and halted flag
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWb.valid    <= 1'b0;
      memWb.regWrite <= 1'b0;
      memWb.memToReg <= 1'b0;
      memWb.halt     <= 1'b0;
      halted         <= 1'b0;
    end else begin
      memWb.valid    <= exMem.valid;
      memWb.regWrite <= exMem.regWrite;
      memWb.memToReg <= exMem.memRead;
      memWb.halt     <= exMem.halt;
      memWb.aluRes   <= exMem.aluRes;
      memWb.loadData <= loadData;
      memWb.dest     <= exMem.dest;
      if (memWb.valid && memWb.halt) begin
        halted <= 1'b1;  // sticky until reset
      end
    end
  end

  // ------------------------------------------------------------
  // writeback
  // ------------------------------------------------------------
  assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluRes;

  assign wbFwd.regWrite = memWb.valid && memWb.regWrite;
  assign wbFwd.dest     = memWb.dest;
  assign wbFwd.data     = wbData;

  // r0 writes are dropped, so not reported
  assign commit.valid = memWb.valid && memWb.regWrite && memWb.dest != '0;
  assign commit.rd    = memWb.dest;
  assign commit.data  = wbData;

endmodule

// File: rtl/mipsPipe.sv
`timescale 1ns/1ps

module mipsPipe (
  input  logic            clk,
  input  logic            rstN,
  input  mipsPkg::progWrS progWr,
  output mipsPkg::commitS commit,
  output logic            halted
);
  import mipsPkg::*;

  // ------------------------------------------------------------
  // stage buses
  // ------------------------------------------------------------
  ifIdS             ifId;
  idExS             idEx;
  exMemS            exMem;
  fwdS              exFwd;   // EX/MEM result
  fwdS              wbFwd;   // writeback result, also regfile write
  logic             stall;
  logic             redirect;
  logic [dataW-1:0] redirectPc;
  logic             halt;

  fetchStage uFetch (
    .clk        (clk),
    .rstN       (rstN),
    .progWr     (progWr),
    .stall      (stall),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .halt       (halt),
    .ifId       (ifId)
  );

  decodeStage uDecode (
    .clk        (clk),
    .rstN       (rstN),
    .ifId       (ifId),
    .exMem      (exMem),     // load-in-MEM check
    .exFwd      (exFwd),
    .wbFwd      (wbFwd),
    .stall      (stall),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .halt       (halt),
    .idEx       (idEx)
  );

  executeStage uExecute (
    .clk   (clk),
    .rstN  (rstN),
    .idEx  (idEx),
    .wbFwd (wbFwd),
    .exMem (exMem),
    .exFwd (exFwd)
  );

  memStage uMem (
    .clk    (clk),
    .rstN   (rstN),
    .exMem  (exMem),
    .wbFwd  (wbFwd),
    .commit (commit),
    .halted (halted)
  );

endmodule

// File: dv/mipsPipe_asserts.sv
`timescale 1ns/1ps

module mipsPipeAsserts (
  input logic            clk,
  input logic            rstN,
  input mipsPkg::commitS commit,
  input logic            halted
);

  // ------------------------------------------------------------
  // commit port rules
  // ------------------------------------------------------------

  // sync reset clears MEM/WB on the edge where it is sampled
  noCommitInReset: assert property (@(posedge clk) !rstN |=> !commit.valid)
    else $error("commit reported while reset is held");

  // r0 writes never show up
  noCommitToR0: assert property (@(posedge clk) commit.valid |-> commit.rd != '0)
    else $error("commit reported with rd of zero");

  // ------------------------------------------------------------
  // halted flag
  // ------------------------------------------------------------
  haltedSticky: assert property (@(posedge clk) halted && rstN |=> halted)
    else $error("halted dropped without a reset");

  // everything older than the halt is already out
  noCommitAfterHalt: assert property (@(posedge clk) halted |-> !commit.valid)
    else $error("commit reported after halted was raised");

endmodule

// File: dv/mipsPipeTb.sv
`timescale 1ns/1ps

module mipsPipeTb;
  import mipsPkg::*;

  localparam int clkPeriod     = 20;
  localparam int resetCycles   = 16;  // also the load window, one word per cycle
  localparam int cyclesPerWord = 10;
  localparam int drainCycles   = 3;   // watch for stray commits after halted

  logic   clk;
  logic   rstN;
  progWrS progWr;
  commitS commit;
  logic   halted;

  // ------------------------------------------------------------
  // case table, flattened into queues
  // ------------------------------------------------------------
  string               caseName  [$];
  int                  progFirst [$];
  int                  progCount [$];
  int                  expFirst  [$];
  int                  expCount  [$];
  logic [dataW-1:0]    progWord  [$];
  logic [regAddrW-1:0] expRd     [$];
  logic [dataW-1:0]    expData   [$];

  int    cycleBudget;   // watchdog limit, 0 until cases are read
  bit    running;       // monitor enable
  int    expIdx;        // next expected commit
  int    expEnd;
  string curName;

  mipsPipe u_mipsPipe (
    .clk    (clk),
    .rstN   (rstN),
    .progWr (progWr),
    .commit (commit),
    .halted (halted)
  );

  bind mipsPipe mipsPipeAsserts uAsserts (
    .clk    (clk),
    .rstN   (rstN),
    .commit (commit),
    .halted (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string testName, input string field,
                            input logic [dataW-1:0] expVal, input logic [dataW-1:0] actVal);
    if (actVal !== expVal) begin
      failRun($sformatf("** Error %s %s: expected %h, actual %h",
                        testName, field, expVal, actVal));
    end
  endtask

  // C, P and E lines; anything else is a comment
  task automatic readCases();
    int               fd;
    int               n;
    int               rd;
    int               last;
    string            line;
    string            name;
    logic [dataW-1:0] word;
    fd = $fopen("dv/mipsPipe_cases.txt", "r");
    if (fd == 0) begin
      failRun("could not open dv/mipsPipe_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      last = caseName.size() - 1;
      if (n > 0 && line.len() > 0) begin
        case (line[0])
          "C": begin
            n = $sscanf(line, "C %s", name);
            caseName.push_back(name);
            progFirst.push_back(progWord.size());
            progCount.push_back(0);
            expFirst.push_back(expRd.size());
            expCount.push_back(0);
          end
          "P": begin
            n = $sscanf(line, "P %h", word);
            if (n != 1 || last < 0) begin
              failRun($sformatf("bad program line in cases file: %s", line));
            end
            progWord.push_back(word);
            progCount[last] = progCount[last] + 1;
          end
          "E": begin
            n = $sscanf(line, "E %d %h", rd, word);
            if (n != 2 || last < 0) begin
              failRun($sformatf("bad expect line in cases file: %s", line));
            end
            expRd.push_back(rd[regAddrW-1:0]);
            expData.push_back(word);
            expCount[last] = expCount[last] + 1;
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------------------
  // reset window with program load
  // ------------------------------------------------------------
  task automatic loadProgram(input int c);
    for (int i = 0; i < resetCycles; i++) begin
      @(posedge clk);
      rstN <= 1'b0;
      if (i < progCount[c]) begin
        progWr.en   <= 1'b1;
        progWr.addr <= imemAddrW'(i);
        progWr.data <= progWord[progFirst[c] + i];
      end else begin
        progWr <= '0;
      end
    end
    @(posedge clk);
    progWr <= '0;
    rstN   <= 1'b1;
  endtask

  // commits sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (running && commit.valid) begin
      if (expIdx >= expEnd) begin
        failRun($sformatf("%s: unexpected commit to r%0d with %h",
                          curName, commit.rd, commit.data));
      end else begin
        checkValue(curName, "rd", dataW'(expRd[expIdx]), dataW'(commit.rd));
        checkValue(curName, "data", expData[expIdx], commit.data);
        expIdx = expIdx + 1;
      end
    end
  end

  initial begin
    wait (cycleBudget > 0);
    repeat (cycleBudget) @(posedge clk);
    failRun($sformatf("timeout: run still going after %0d cycles", cycleBudget));
  end

  initial begin
    int budget;
    rstN    = 1'b0;
    progWr  = '0;
    running = 1'b0;
    budget  = 0;
    readCases();
    if (caseName.size() == 0) begin
      failRun("no cases found in dv/mipsPipe_cases.txt");
    end
    for (int c = 0; c < caseName.size(); c++) begin
      if (progCount[c] > resetCycles) begin
        failRun($sformatf("%s: program longer than the load window", caseName[c]));
      end
      budget = budget + resetCycles + cyclesPerWord * progCount[c];
    end
    cycleBudget = budget;

    for (int c = 0; c < caseName.size(); c++) begin
      curName = caseName[c];
      expIdx  = expFirst[c];
      expEnd  = expFirst[c] + expCount[c];
      loadProgram(c);
      running = 1'b1;
      while (!halted) @(negedge clk);
      if (expIdx != expEnd) begin
        failRun($sformatf("%s: halted with %0d expected commits missing",
                          curName, expEnd - expIdx));
      end
      repeat (drainCycles) @(negedge clk);
      @(posedge clk);
      running = 1'b0;
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: mipsPipe.f
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memStage.sv
rtl/mipsPipe.sv
dv/mipsPipe_asserts.sv
dv/mipsPipeTb.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module mipsPipeTb \
  -f mipsPipe.f \
  -o mipsPipeSim &&
./obj_dir/mipsPipeSim | tee /dev/stderr | grep "Test OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: dv/mipsPipe_cases.txt
# C <case name> | P <instruction word, hex>
# E <rd, decimal> <write data, hex>   expected commits in program order
C arithChain
P 20010005  # addi r1, r0, 5
P 2022FFF9  # addi r2, r1, -7
P 00221820  # add  r3, r1, r2
P 00612022  # sub  r4, r3, r1
P 0081282A  # slt  r5, r4, r1
P 00033100  # sll  r6, r3, 4
P 34C70F05  # ori  r7, r6, 0x0f05
P 30E800FC  # andi r8, r7, 0x00fc
P 01024825  # or   r9, r8, r2
P FC000000  # halt
E 1 00000005
E 2 FFFFFFFE
E 3 00000003
E 4 FFFFFFFE
E 5 00000001
E 6 00000030
E 7 00000F35
E 8 00000034
E 9 FFFFFFFE
C loadStore
P 20011234  # addi r1, r0, 0x1234
P 20020008  # addi r2, r0, 8
P AC410004  # sw   r1, 4(r2)
P 8C03000C  # lw   r3, 12(r0)
P 00632020  # add  r4, r3, r3
P 8C450004  # lw   r5, 4(r2)
P 00A13022  # sub  r6, r5, r1
P AC040000  # sw   r4, 0(r0)
P 8C070000  # lw   r7, 0(r0)
P FC000000  # halt
E 1 00001234
E 2 00000008
E 3 00001234
E 4 00002468
E 5 00001234
E 6 00000000
E 7 00002468
C branches
P 20010003  # addi r1, r0, 3
P 20020003  # addi r2, r0, 3
P 10220001  # beq  r1, r2, +1  taken
P 20030099  # addi r3, r0, 0x99  squashed
P 20040001  # addi r4, r0, 1
P 10810001  # beq  r4, r1, +1  not taken
P 20050007  # addi r5, r0, 7
P 14A00002  # bne  r5, r0, +2  taken
P 20060066  # addi r6, r0, 0x66  skipped
P 20070077  # addi r7, r0, 0x77  skipped
P 00254020  # add  r8, r1, r5
P FC000000  # halt
E 1 00000003
E 2 00000003
E 4 00000001
E 5 00000007
E 8 0000000A
C jumpHalt
P 20010011  # addi r1, r0, 0x11
P 08000004  # j    word 4
P 20010022  # addi r1, r0, 0x22  skipped
P 20020033  # addi r2, r0, 0x33  skipped
P 20230001  # addi r3, r1, 1
P FC000000  # halt
P 20040044  # addi r4, r0, 0x44  past the halt
E 1 00000011
E 3 00000012
C regZero
P 20000005  # addi r0, r0, 5
P 00000820  # add  r1, r0, r0
P 3400FFFF  # ori  r0, r0, 0xffff
P 20020009  # addi r2, r0, 9
P 00020080  # sll  r0, r2, 2
P 00021825  # or   r3, r0, r2
P FC000000  # halt
E 1 00000000
E 2 00000009
E 3 00000009
